/* filelist.f */
common/pipearch_pkg.sv
common/fifobram_if.sv
logic/region_bram.sv
loadreg/pipearch_loadreg.sv
logic/host_regs.sv
logic/pipearch_top.sv
tb/pipearch_asserts.sv
tb/pipearch_tb.sv

/* Bender.yml */
package:
  name: pipearch

sources:
  - files:
      - common/pipearch_pkg.sv
      - common/fifobram_if.sv
      - logic/region_bram.sv
      - loadreg/pipearch_loadreg.sv
      - logic/host_regs.sv
      - logic/pipearch_top.sv
  - target: test
    files:
      - tb/pipearch_asserts.sv
      - tb/pipearch_tb.sv

/* tb/pipearch_tb.sv */
module pipearch_tb;

    localparam int NUM_LOADS      = 16;
    localparam int NUM_LINES      = 8;
    localparam int TIMEOUT_CYCLES = NUM_LOADS * 40 + 2000; // Loads plus the line fills

    typedef struct {
        string               name;
        pipearch_pkg::word_t arg0;
        pipearch_pkg::word_t arg1;
        pipearch_pkg::word_t arg2;
        int                  target; // 3 or 4 or else 0 when no result changes
    } load_t;

    logic                              clk;
    logic                              reset;
    logic                              cyc;
    logic                              stb;
    logic                              we;
    logic [pipearch_pkg::ADR_BITS-1:0] adr;
    pipearch_pkg::word_t               dat_w;
    logic                              ack;
    pipearch_pkg::word_t               dat_r;

    int                  errors;
    int                  cycle_count;
    int                  start_count;
    logic [31:0]         rng;
    pipearch_pkg::word_t model [256][16]; // Mirror of committed lines
    pipearch_pkg::word_t exp_out3;
    pipearch_pkg::word_t exp_out4;

    int    commit_lines [NUM_LINES] = '{0, 3, 7, 10, 16, 42, 128, 255};
    load_t loads [NUM_LOADS] = '{
        '{"line0_pos0",      32'h0000_0000, 32'd3,          32'h0000_0000, 3},
        '{"line0_pos15",     32'h0000_000f, 32'd4,          32'h0000_0000, 4},
        '{"line3_pos7",      32'h0000_0007, 32'd3,          32'h0000_0003, 3},
        '{"base_wrap_16",    32'h0000_0105, 32'd4,          32'h0000_0010, 4},
        '{"line42_pos15",    32'h0000_002f, 32'd3,          32'h0000_000a, 3},
        '{"line255_pos3",    32'h0000_00f3, 32'd4,          32'h0000_000f, 4},
        '{"wrap_to_10",      32'h0000_0081, 32'd3,          32'h0000_008a, 3},
        '{"offset_high",     32'h0000_0002, 32'd4,          32'h0001_0080, 4},
        '{"target0",         32'h0000_0004, 32'd0,          32'h0000_0007, 0},
        '{"target1",         32'h0000_0009, 32'd1,          32'h0000_0003, 0},
        '{"target2",         32'h0000_001e, 32'd2,          32'h0000_00fa, 0},
        '{"target5",         32'h0000_000c, 32'd5,          32'h0000_00ff, 0},
        '{"target6",         32'h0000_0030, 32'd6,          32'h0000_00fa, 0},
        '{"target7",         32'h0000_0011, 32'd7,          32'h0000_0000, 0},
        '{"arg1_high_bits",  32'h0000_000b, 32'h0000_000b,  32'h0000_0007, 3},
        '{"arg0_all_ones",   32'hffff_ffff, 32'd3,          32'h0000_0010, 3}
    };

    pipearch_top #(.REGION_AW(8)) dut_i
    (
        .clk   (clk),
        .reset (reset),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .ack   (ack),
        .dat_r (dat_r)
    );

    always #10 clk = ~clk;

    // Run limit
    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout: run stopped after %0d cycles, errors %0d", cycle_count, errors);
            $display("Finished with errors");
            $finish;
        end
    end

    always @(posedge clk)
    begin
        if (dut_i.op_start === 1'b1)
        begin
            start_count <= start_count + 1; // Starts the host stage passed on
        end
    end

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Line is offset plus index base modulo 256, position is arg0 modulo 16
    function automatic pipearch_pkg::word_t model_word(input load_t ld);
        pipearch_pkg::word_t line_idx;
        line_idx = (ld.arg2 + (ld.arg0 & ~32'hf)) % 256;
        return model[line_idx][ld.arg0 % 16];
    endfunction

    // Only the result register that the target selects takes the new word
    task automatic predict_results(input load_t ld);
        if (ld.target == 3)
        begin
            exp_out3 = model_word(ld);
        end
        else if (ld.target == 4)
        begin
            exp_out4 = model_word(ld);
        end
    endtask

    task automatic check_word(input string name, input pipearch_pkg::word_t exp,
                              input pipearch_pkg::word_t act);
        assert (act === exp)
        else
        begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // Ack is due one cycle after the edge that accepts the access
    task automatic await_ack(input logic [pipearch_pkg::ADR_BITS-1:0] a);
        int waited;
        waited = 0;
        @(posedge clk);
        while (ack !== 1'b1)
        begin
            @(posedge clk);
            waited++;
        end
        check_word($sformatf("ack_delay_adr%0d", a), 32'd1, waited);
    endtask

    task automatic bus_write(input logic [pipearch_pkg::ADR_BITS-1:0] a,
                             input pipearch_pkg::word_t d);
        @(posedge clk);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= 1'b1;
        adr   <= a;
        dat_w <= d;
        await_ack(a);
        cyc <= 1'b0; // Drop the strobe after the ack
        stb <= 1'b0;
        we  <= 1'b0;
    endtask

    task automatic bus_read(input logic [pipearch_pkg::ADR_BITS-1:0] a,
                            output pipearch_pkg::word_t d);
        @(posedge clk);
        cyc <= 1'b1;
        stb <= 1'b1;
        we  <= 1'b0;
        adr <= a;
        await_ack(a);
        d = dat_r;
        cyc <= 1'b0;
        stb <= 1'b0;
    endtask

    // Stage sixteen random words and commit them to one line
    task automatic fill_line(input int line);
        pipearch_pkg::word_t rd;
        for (int w = 0; w < 16; w++)
        begin
            rng = next_random(rng);
            model[line][w] = rng;
            bus_write(pipearch_pkg::REG_STAGE_BASE + w, rng);
        end
        bus_read(pipearch_pkg::REG_STAGE_BASE + 15, rd);
        check_word($sformatf("stage_line%0d", line), model[line][15], rd);
        bus_write(pipearch_pkg::REG_COMMIT, line);
    endtask

    task automatic run_load(input load_t ld);
        pipearch_pkg::word_t status;
        pipearch_pkg::word_t got;
        bus_write(pipearch_pkg::REG_ARG0, ld.arg0);
        bus_write(pipearch_pkg::REG_ARG1, ld.arg1);
        bus_write(pipearch_pkg::REG_ARG2, ld.arg2);
        bus_write(pipearch_pkg::REG_CMD, 32'h1);
        bus_read(pipearch_pkg::REG_CMD, status);
        check_word({ld.name, "_busy"}, 32'h1, status); // Busy set and old done cleared
        while (status[pipearch_pkg::STAT_DONE] !== 1'b1)
        begin
            bus_read(pipearch_pkg::REG_CMD, status);
        end
        check_word({ld.name, "_done"}, 32'h2, status);
        predict_results(ld);
        bus_read(pipearch_pkg::REG_OUT3, got);
        check_word({ld.name, "_out3"}, exp_out3, got);
        bus_read(pipearch_pkg::REG_OUT4, got);
        check_word({ld.name, "_out4"}, exp_out4, got);
    endtask

    task automatic check_reset_state(input string name);
        pipearch_pkg::word_t got;
        bus_read(pipearch_pkg::REG_CMD, got);
        check_word({name, "_status"}, 32'h0, got);
        bus_read(pipearch_pkg::REG_OUT3, got);
        check_word({name, "_out3"}, 32'h0, got);
        bus_read(pipearch_pkg::REG_OUT4, got);
        check_word({name, "_out4"}, 32'h0, got);
    endtask

    initial
    begin
        pipearch_pkg::word_t got;
        int                  starts_before;
        load_t               twice;
        clk         = 1'b0;
        reset       = 1'b1;
        cyc         = 1'b0;
        stb         = 1'b0;
        we          = 1'b0;
        adr         = '0;
        dat_w       = '0;
        errors      = 0;
        cycle_count = 0;
        start_count = 0;
        rng         = 32'h353d_b207;
        exp_out3    = '0;
        exp_out4    = '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        check_reset_state("after_reset");

        for (int i = 0; i < NUM_LINES; i++)
        begin
            fill_line(commit_lines[i]);
        end

        for (int i = 0; i < NUM_LOADS; i++)
        begin
            run_load(loads[i]);
        end

        // Second start while busy is dropped
        twice = '{"start_twice", 32'h0000_0025, 32'd3, 32'h0000_000a, 3};
        starts_before = start_count;
        bus_write(pipearch_pkg::REG_ARG0, twice.arg0);
        bus_write(pipearch_pkg::REG_ARG1, twice.arg1);
        bus_write(pipearch_pkg::REG_ARG2, twice.arg2);
        bus_write(pipearch_pkg::REG_CMD, 32'h1);
        bus_write(pipearch_pkg::REG_CMD, 32'h1);
        got = '0;
        while (got[pipearch_pkg::STAT_DONE] !== 1'b1)
        begin
            bus_read(pipearch_pkg::REG_CMD, got);
        end
        predict_results(twice);
        bus_read(pipearch_pkg::REG_OUT3, got);
        check_word("start_twice_out3", exp_out3, got);
        bus_read(pipearch_pkg::REG_OUT4, got);
        check_word("start_twice_out4", exp_out4, got);
        check_word("start_twice_count", starts_before + 1, start_count);

        // Reset again with nonzero results
        @(posedge clk);
        reset <= 1'b1;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        check_reset_state("second_reset");

        $display("errors: %0d", errors);
        if (errors == 0)
        begin
            $display("Finished with no errors");
        end
        else
        begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* tb/pipearch_asserts.sv */
module pipearch_asserts
(
    input logic clk,
    input logic reset,
    input logic op_start,
    input logic op_done,
    input logic re,
    input logic rvalid
);

    // Memory answers exactly one cycle after the request
    a_rvalid_follows_re: assert property (@(posedge clk) disable iff (reset)
        re |=> rvalid)
        else $error("rvalid missing one cycle after re");

    a_rvalid_needs_re: assert property (@(posedge clk) disable iff (reset)
        rvalid |-> $past(re))
        else $error("rvalid without re in the previous cycle");

    a_done_after_start: assert property (@(posedge clk) disable iff (reset)
        op_start |-> ##4 op_done)
        else $error("op_done missing four cycles after op_start");

    a_done_needs_start: assert property (@(posedge clk) disable iff (reset)
        op_done |-> $past(op_start, 4))
        else $error("op_done without op_start four cycles earlier");

    a_no_overlap: assert property (@(posedge clk) disable iff (reset)
        !(op_start && op_done))
        else $error("op_start and op_done high together");

endmodule

bind pipearch_loadreg pipearch_asserts asserts_i
(
    .clk      (clk),
    .reset    (reset),
    .op_start (op_start),
    .op_done  (op_done),
    .re       (region_read.re),
    .rvalid   (region_read.rvalid)
);

/* logic/pipearch_top.sv */
module pipearch_top #(
    parameter int REGION_AW = 8
)
(
    input  logic                              clk,
    input  logic                              reset,

    input  logic                              cyc,
    input  logic                              stb,
    input  logic                              we,
    input  logic [pipearch_pkg::ADR_BITS-1:0] adr,
    input  pipearch_pkg::word_t               dat_w,
    output logic                              ack,
    output pipearch_pkg::word_t               dat_r
);

    logic                 op_start;
    logic                 op_done;
    pipearch_pkg::word_t  args [3];
    pipearch_pkg::word_t  res3;
    pipearch_pkg::word_t  res4;

    logic                 line_we;
    logic [REGION_AW-1:0] line_addr;
    pipearch_pkg::line_t  line_data;

    fifobram_if #(.REGION_AW(REGION_AW)) region_bus ();

    host_regs #(.REGION_AW(REGION_AW)) host_i
    (
        .clk       (clk),
        .reset     (reset),
        .cyc       (cyc),
        .stb       (stb),
        .we        (we),
        .adr       (adr),
        .dat_w     (dat_w),
        .ack       (ack),
        .dat_r     (dat_r),
        .op_start  (op_start),
        .args      (args),
        .op_done   (op_done),
        .res3      (res3),
        .res4      (res4),
        .line_we   (line_we),
        .line_addr (line_addr),
        .line_data (line_data)
    );

    pipearch_loadreg #(.REGION_AW(REGION_AW)) loadreg_i
    (
        .clk         (clk),
        .reset       (reset),
        .op_start    (op_start),
        .op_done     (op_done),
        .regs        (args),
        .res3        (res3),
        .res4        (res4),
        .region_read (region_bus.reader)
    );

    region_bram #(.REGION_AW(REGION_AW)) bram_i
    (
        .clk        (clk),
        .reset      (reset),
        .line_we    (line_we),
        .line_addr  (line_addr),
        .line_data  (line_data),
        .region_mem (region_bus.memory)
    );

endmodule

/* logic/host_regs.sv */
module host_regs #(
    parameter int REGION_AW = 8
)
(
    input  logic                              clk,
    input  logic                              reset,

    // Wishbone classic slave
    input  logic                              cyc,
    input  logic                              stb,
    input  logic                              we,
    input  logic [pipearch_pkg::ADR_BITS-1:0] adr,
    input  pipearch_pkg::word_t               dat_w,
    output logic                              ack,
    output pipearch_pkg::word_t               dat_r,

    // Load unit
    output logic                              op_start,
    output pipearch_pkg::word_t               args [3],
    input  logic                              op_done,
    input  pipearch_pkg::word_t               res3,
    input  pipearch_pkg::word_t               res4,

    // Line memory write port
    output logic                              line_we,
    output logic [REGION_AW-1:0]              line_addr,
    output pipearch_pkg::line_t               line_data
);

    logic                              access;    // First cycle of a bus access
    logic                              wr_en;
    logic                              start_req;
    logic [pipearch_pkg::ADR_BITS-1:0] stage_off;
    logic                              stage_hit;
    logic                              busy;
    logic                              done;
    pipearch_pkg::line_t               stage_line;
    pipearch_pkg::word_t               out3;
    pipearch_pkg::word_t               out4;
    pipearch_pkg::word_t               rd_word;

    assign access    = cyc && stb && !ack; // Ack high blocks a second accept
    assign wr_en     = access && we;
    assign start_req = wr_en && (adr == pipearch_pkg::REG_CMD) && dat_w[pipearch_pkg::CMD_START];

    // Below the base the difference wraps high and misses
    assign stage_off = adr - pipearch_pkg::REG_STAGE_BASE;
    assign stage_hit = (stage_off < pipearch_pkg::ADR_BITS'(pipearch_pkg::LINE_WORDS));

    // Commit lands in the memory at the edge that raises ack
    assign line_we   = wr_en && (adr == pipearch_pkg::REG_COMMIT);
    assign line_addr = dat_w[REGION_AW-1:0];
    assign line_data = stage_line;

    always_comb
    begin
        rd_word = '0; // Unmapped addresses read zero
        if (stage_hit)
        begin
            rd_word = stage_line[stage_off[pipearch_pkg::POS_BITS-1:0] * pipearch_pkg::WORD_BITS
                                 +: pipearch_pkg::WORD_BITS];
        end
        else
        begin
            case (adr)
                pipearch_pkg::REG_ARG0: rd_word = args[0];
                pipearch_pkg::REG_ARG1: rd_word = args[1];
                pipearch_pkg::REG_ARG2: rd_word = args[2];
                pipearch_pkg::REG_CMD:
                begin
                    rd_word[pipearch_pkg::STAT_BUSY] = busy;
                    rd_word[pipearch_pkg::STAT_DONE] = done;
                end
                pipearch_pkg::REG_OUT3: rd_word = out3;
                pipearch_pkg::REG_OUT4: rd_word = out4;
                default:                rd_word = '0;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ack <= 1'b0;
        end
        else
        begin
            ack <= access; // Single-cycle ack
        end
    end

    always_ff @(posedge clk)
    begin
        if (access && !we)
        begin
            dat_r <= rd_word;
        end
    end

    // Arguments and staging words
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            case (adr)
                pipearch_pkg::REG_ARG0: args[0] <= dat_w;
                pipearch_pkg::REG_ARG1: args[1] <= dat_w;
                pipearch_pkg::REG_ARG2: args[2] <= dat_w;
                default:                ;
            endcase
            if (stage_hit)
            begin
                stage_line[stage_off[pipearch_pkg::POS_BITS-1:0] * pipearch_pkg::WORD_BITS
                           +: pipearch_pkg::WORD_BITS] <= dat_w;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            op_start <= 1'b0;
            busy     <= 1'b0;
            done     <= 1'b0;
            out3     <= '0;
            out4     <= '0;
        end
        else
        begin
            op_start <= start_req && !busy; // Start while busy is dropped
            if (start_req && !busy)
            begin
                busy <= 1'b1;
                done <= 1'b0;
            end
            else if (op_done)
            begin
                busy <= 1'b0;
                done <= 1'b1;
            end
            if (op_done)
            begin
                out3 <= res3;
                out4 <= res4;
            end
        end
    end

endmodule

/* loadreg/pipearch_loadreg.sv */
module pipearch_loadreg #(
    parameter int REGION_AW = 8
)
(
    input  logic                clk,
    input  logic                reset,

    input  logic                op_start,
    output logic                op_done,

    input  pipearch_pkg::word_t regs [3],
    output pipearch_pkg::word_t res3,
    output pipearch_pkg::word_t res4,

    fifobram_if.reader          region_read
);

    typedef enum logic [1:0]
    {
        ST_IDLE,
        ST_READ,
        ST_RECEIVE
    } state_t;

    state_t state;

    // Operation fields, latched on the start
    logic [pipearch_pkg::OFFSET_BITS-1:0] index_base;
    logic [pipearch_pkg::POS_BITS-1:0]    word_pos;
    logic [2:0]                           target;
    logic [pipearch_pkg::OFFSET_BITS-1:0] line_offset;

    logic [pipearch_pkg::OFFSET_BITS-1:0] line_sum;
    pipearch_pkg::word_t                  picked;

    assign line_sum = line_offset + index_base;

    // Selected word of the returned line
    assign picked = region_read.rdata[word_pos * pipearch_pkg::WORD_BITS
                                      +: pipearch_pkg::WORD_BITS];

    always_ff @(posedge clk)
    begin
        if (state == ST_IDLE && op_start)
        begin
            index_base  <= {regs[0][pipearch_pkg::OFFSET_BITS-1:pipearch_pkg::POS_BITS],
                            pipearch_pkg::POS_BITS'(0)};
            word_pos    <= regs[0][pipearch_pkg::POS_BITS-1:0];
            target      <= regs[1][2:0];
            line_offset <= regs[2][pipearch_pkg::OFFSET_BITS-1:0];
        end
        if (state == ST_READ)
        begin
            region_read.raddr <= line_sum[REGION_AW-1:0]; // Wraps to the memory size
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state          <= ST_IDLE;
            region_read.re <= 1'b0;
            op_done        <= 1'b0;
            res3           <= '0;
            res4           <= '0;
        end
        else
        begin
            region_read.re <= 1'b0;
            op_done        <= 1'b0;

            case (state)
                ST_IDLE:
                begin
                    if (op_start)
                    begin
                        state <= ST_READ;
                    end
                end

                ST_READ:
                begin
                    region_read.re <= 1'b1;
                    state          <= ST_RECEIVE;
                end

                ST_RECEIVE:
                begin
                    if (region_read.rvalid)
                    begin
                        // Other targets complete without touching a result
                        if (target == pipearch_pkg::TARGET_OUT3)
                        begin
                            res3 <= picked;
                        end
                        else if (target == pipearch_pkg::TARGET_OUT4)
                        begin
                            res4 <= picked;
                        end
                        op_done <= 1'b1;
                        state   <= ST_IDLE;
                    end
                end

                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

/* logic/region_bram.sv */
module region_bram #(
    parameter int REGION_AW = 8
)
(
    input  logic                 clk,
    input  logic                 reset,

    // Whole-line writes from the host stage
    input  logic                 line_we,
    input  logic [REGION_AW-1:0] line_addr,
    input  pipearch_pkg::line_t  line_data,

    fifobram_if.memory           region_mem
);

    localparam int DEPTH = 2 ** REGION_AW;

    pipearch_pkg::line_t lines [DEPTH];

    // Write port
    always_ff @(posedge clk)
    begin
        if (line_we)
        begin
            lines[line_addr] <= line_data;
        end
    end

    // Registered read, old contents on a same-cycle write
    always_ff @(posedge clk)
    begin
        if (region_mem.re)
        begin
            region_mem.rdata <= lines[region_mem.raddr];
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            region_mem.rvalid <= 1'b0;
        end
        else
        begin
            region_mem.rvalid <= region_mem.re; // Answer always one cycle later
        end
    end

endmodule

/* common/fifobram_if.sv */
interface fifobram_if #(
    parameter int REGION_AW = 8
);

    logic                 re;     // Read request
    logic [REGION_AW-1:0] raddr;  // Line address, valid with re
    logic                 rvalid; // One cycle after re
    pipearch_pkg::line_t  rdata;  // Line at raddr, valid with rvalid

    // Load unit side
    modport reader
    (
        output re,
        output raddr,
        input  rvalid,
        input  rdata
    );

    // Line memory side
    modport memory
    (
        input  re,
        input  raddr,
        output rvalid,
        output rdata
    );

endinterface

/* common/pipearch_pkg.sv */
package pipearch_pkg;

    // Data sizes
    localparam int WORD_BITS   = 32;
    localparam int LINE_WORDS  = 16;
    localparam int LINE_BITS   = WORD_BITS * LINE_WORDS; // 512-bit line
    localparam int POS_BITS    = $clog2(LINE_WORDS);     // Word index within a line
    localparam int OFFSET_BITS = 16;                     // Line offset taken from arg2

    // Host bus word address width
    localparam int ADR_BITS = 6;

    typedef logic [WORD_BITS-1:0] word_t;
    typedef logic [LINE_BITS-1:0] line_t;

    // Register map, word addresses on the host bus
    localparam logic [ADR_BITS-1:0] REG_ARG0 = ADR_BITS'(0); // Index argument
    localparam logic [ADR_BITS-1:0] REG_ARG1 = ADR_BITS'(1); // Target register number
    localparam logic [ADR_BITS-1:0] REG_ARG2 = ADR_BITS'(2); // Line offset
    localparam logic [ADR_BITS-1:0] REG_CMD  = ADR_BITS'(3); // Start on write, status on read
    localparam logic [ADR_BITS-1:0] REG_OUT3 = ADR_BITS'(4);
    localparam logic [ADR_BITS-1:0] REG_OUT4 = ADR_BITS'(5);

    // Staging words 0 to 15 sit at 16 to 31
    localparam logic [ADR_BITS-1:0] REG_STAGE_BASE = ADR_BITS'(16);

    // Write data is the line address that receives the staged words
    localparam logic [ADR_BITS-1:0] REG_COMMIT = ADR_BITS'(32);

    // Bit positions in REG_CMD
    localparam int CMD_START = 0; // Write side
    localparam int STAT_BUSY = 0; // Read side
    localparam int STAT_DONE = 1; // Sticky, cleared by the next start

    // Result register numbers that arg1 can select
    localparam logic [2:0] TARGET_OUT3 = 3'd3;
    localparam logic [2:0] TARGET_OUT4 = 3'd4;

endpackage
